// File: mem_bus_top.f
mem_bus_pkg.sv
bus_port.sv
bus_arbiter.sv
sram_bank.sv
uart_regs.sv
mem_bus_top.sv
tb_mem_bus_top.sv

// File: Bender.yml
package:
  name: mem_bus_top

sources:
  - mem_bus_pkg.sv
  - bus_port.sv
  - bus_arbiter.sv
  - sram_bank.sv
  - uart_regs.sv
  - mem_bus_top.sv
  - target: test
    files:
      - tb_mem_bus_top.sv

// File: tb_mem_bus_top.sv
module tb_mem_bus_top;

    localparam int   BANK_WORDS = 256;
    localparam int   MAX_CYCLES = 4000;  // about ten times the full run
    localparam logic PORT_FETCH = 1'b0;
    localparam logic PORT_DATA  = 1'b1;

    logic                  clk_25M = 1'b0;
    logic                  rst_i;
    logic                  fetch_req_i, data_req_i;
    mem_bus_pkg::bus_req_t fetch_cmd_i, data_cmd_i;
    logic                  fetch_ack_o, data_ack_o;
    mem_bus_pkg::bus_rsp_t fetch_rsp_o, data_rsp_o;
    logic                  tx_valid_o, rx_valid_i, rx_ack_o;
    logic                  tx_ack_i = 1'b0;
    logic [7:0]            tx_data_o, rx_data_i;

    logic [31:0] base_sb [BANK_WORDS];  // expected bank contents
    logic [31:0] ext_sb  [BANK_WORDS];
    logic [7:0]  tx_seen [$];           // bytes taken by the serial responder
    logic        tx_hold = 1'b0;        // holds back tx_ack_i
    integer      seed = 32'h0a49_8364;
    int          cycles = 0;
    int          test_errs, fail_tests, total_errs;

    mem_bus_top #(.BANK_WORDS(BANK_WORDS)) i_mem_bus_top (.*);

    initial begin
        forever #20 clk_25M = ~clk_25M;
    end

    always @(posedge clk_25M) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: ack never arrived");
            $display("TEST FAIL");
            $finish;
        end
    end

    // serial side responder for the transmit handshake
    always @(negedge clk_25M) begin
        if (tx_valid_o && !tx_ack_i && !tx_hold) begin
            tx_seen.push_back(tx_data_o);
            tx_ack_i <= 1'b1;
        end else if (!tx_valid_o) begin
            tx_ack_i <= 1'b0;
        end
    end

    function automatic logic [31:0] merge(logic [31:0] old_w, logic [31:0] new_w,
                                          logic [3:0] mask);
        logic [31:0] w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) w[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return w;
    endfunction

    function automatic logic [31:0] sb_read(logic [31:0] addr);
        int idx;
        idx = (addr >> 2) % BANK_WORDS;  // aliases inside a window
        return (addr >= mem_bus_pkg::EXT_START) ? ext_sb[idx] : base_sb[idx];
    endfunction

    task automatic sb_write(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] mask);
        int idx;
        idx = (addr >> 2) % BANK_WORDS;
        if (addr >= mem_bus_pkg::EXT_START) ext_sb[idx] = merge(ext_sb[idx], wdata, mask);
        else base_sb[idx] = merge(base_sb[idx], wdata, mask);
    endtask

    function automatic mem_bus_pkg::bus_req_t make_cmd(logic write, logic [31:0] addr,
                                                       logic [31:0] wdata, logic [3:0] mask);
        mem_bus_pkg::bus_req_t c;
        c.write = write;
        c.addr  = addr;
        c.wdata = wdata;
        c.mask  = mask;
        return c;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    // one four-phase transfer on either port
    task automatic bus_xfer(input logic port, input mem_bus_pkg::bus_req_t cmd,
                            output mem_bus_pkg::bus_rsp_t rsp);
        @(negedge clk_25M);
        if (port == PORT_DATA) begin
            data_cmd_i = cmd;
            data_req_i = 1'b1;
            @(negedge clk_25M);
            while (!data_ack_o) @(negedge clk_25M);
            rsp = data_rsp_o;
            data_req_i = 1'b0;
            while (data_ack_o) @(negedge clk_25M);
        end else begin
            fetch_cmd_i = cmd;
            fetch_req_i = 1'b1;
            @(negedge clk_25M);
            while (!fetch_ack_o) @(negedge clk_25M);
            rsp = fetch_rsp_o;
            fetch_req_i = 1'b0;
            while (fetch_ack_o) @(negedge clk_25M);
        end
    endtask

    task automatic write_word(input logic port, input logic [31:0] addr, input logic [3:0] mask);
        mem_bus_pkg::bus_rsp_t rsp;
        logic [31:0]           wdata;
        wdata = $random(seed);
        sb_write(addr, wdata, mask);
        bus_xfer(port, make_cmd(1'b1, addr, wdata, mask), rsp);
        check_val("data_rsp_o.fault", rsp.fault, 0);
    endtask

    task automatic read_expect(input logic port, input logic [31:0] addr,
                               input logic [31:0] exp);
        mem_bus_pkg::bus_rsp_t rsp;
        bus_xfer(port, make_cmd(1'b0, addr, '0, 4'hF), rsp);
        check_val(port ? "data_rsp_o.rdata" : "fetch_rsp_o.rdata", rsp.rdata, exp);
        check_val(port ? "data_rsp_o.fault" : "fetch_rsp_o.fault", rsp.fault, 0);
    endtask

    task automatic read_check(input logic port, input logic [31:0] addr);
        read_expect(port, addr, sb_read(addr));
    endtask

    task automatic write_uart(input logic [7:0] b);
        mem_bus_pkg::bus_rsp_t rsp;
        bus_xfer(PORT_DATA, make_cmd(1'b1, mem_bus_pkg::UART_DATA_ADDR, {24'h0, b}, 4'h1), rsp);
        check_val("data_rsp_o.fault", rsp.fault, 0);
    endtask

    task automatic wait_tx_drained(input int n);
        while (tx_seen.size() < n || tx_valid_o) @(negedge clk_25M);
    endtask

    task automatic report_test(input string name);
        $display("%-22s %s, %0d errors", name, test_errs == 0 ? "ok" : "FAILED", test_errs);
        if (test_errs != 0) fail_tests++;
        total_errs += test_errs;
    endtask

    task automatic test_base_masks();
        logic [15:0] masks;
        logic [31:0] addr;
        test_errs = 0;
        masks = 16'hA861;
        for (int i = 0; i < 8; i++) begin
            addr = mem_bus_pkg::BASE_START + 32'h40 * i + 32'h4;
            write_word(PORT_DATA, addr, 4'hF);
            write_word(PORT_DATA, addr, masks[(i % 4) * 4 +: 4]);
            write_word(PORT_DATA, addr, masks[((i + 1) % 4) * 4 +: 4]);
            read_check(PORT_DATA, addr);
        end
        read_check(PORT_DATA, mem_bus_pkg::BASE_START + BANK_WORDS * 4 + 32'h4);  // alias
        report_test("base masked writes");
    endtask

    task automatic test_ext_fetch();
        test_errs = 0;
        for (int i = 0; i < 6; i++) begin
            write_word(PORT_DATA, mem_bus_pkg::EXT_START + 32'h8 * i, 4'hF);
        end
        for (int i = 0; i < 6; i++) begin
            read_check(PORT_FETCH, mem_bus_pkg::EXT_START + 32'h8 * i);
        end
        report_test("ext fetch reads");
    endtask

    task automatic test_same_bank();
        mem_bus_pkg::bus_rsp_t d_rsp;
        logic [31:0]           addr, exp_old, wdata;
        test_errs = 0;
        addr = mem_bus_pkg::BASE_START + 32'h200;
        write_word(PORT_DATA, addr, 4'hF);
        exp_old = sb_read(addr);
        wdata = $random(seed);
        fork
            read_expect(PORT_FETCH, addr, exp_old);  // fetch wins and sees the old word
            begin
                bus_xfer(PORT_DATA, make_cmd(1'b1, addr, wdata, 4'hF), d_rsp);
                check_val("data_rsp_o.fault", d_rsp.fault, 0);
            end
        join
        sb_write(addr, wdata, 4'hF);
        read_check(PORT_FETCH, addr);
        report_test("same bank clash");
    endtask

    task automatic test_split_banks();
        test_errs = 0;
        fork
            read_check(PORT_FETCH, mem_bus_pkg::BASE_START + 32'h4);
            read_check(PORT_DATA, mem_bus_pkg::EXT_START + 32'h8);
        join
        report_test("split banks");
    endtask

    task automatic test_serial();
        logic third_done;
        test_errs = 0;
        third_done = 1'b0;
        check_val("tx_valid_o", tx_valid_o, 0);
        check_val("rx_ack_o", rx_ack_o, 0);
        read_expect(PORT_DATA, mem_bus_pkg::UART_STAT_ADDR, 32'h1);
        write_uart(8'h5A);
        wait_tx_drained(1);
        tx_hold = 1'b1;
        write_uart(8'hC3);
        fork
            begin
                write_uart(8'h77);
                third_done = 1'b1;
            end
            begin
                read_expect(PORT_FETCH, mem_bus_pkg::UART_STAT_ADDR, 32'h0);
                repeat (8) @(negedge clk_25M);
                assert (!third_done && !data_ack_o) else begin
                    $display("third byte was acked while tx_ack_i was held back");
                    test_errs++;
                end
                tx_hold = 1'b0;
            end
        join
        wait_tx_drained(3);
        check_val("tx_data_o", tx_seen[0], 8'h5A);
        check_val("tx_data_o", tx_seen[1], 8'hC3);
        check_val("tx_data_o", tx_seen[2], 8'h77);

        @(negedge clk_25M);
        rx_data_i  = 8'hA7;
        rx_valid_i = 1'b1;
        while (!rx_ack_o) @(negedge clk_25M);
        rx_valid_i = 1'b0;
        while (rx_ack_o) @(negedge clk_25M);
        read_expect(PORT_DATA, mem_bus_pkg::UART_STAT_ADDR, 32'h3);
        read_expect(PORT_DATA, mem_bus_pkg::UART_DATA_ADDR, 32'hA7);
        read_expect(PORT_DATA, mem_bus_pkg::UART_STAT_ADDR, 32'h1);  // rx emptied by the read
        report_test("serial registers");
    endtask

    task automatic test_unmapped();
        mem_bus_pkg::bus_rsp_t f_rsp, d_rsp;
        test_errs = 0;
        fork
            bus_xfer(PORT_FETCH, make_cmd(1'b0, 32'h0000_1000, '0, 4'hF), f_rsp);
            bus_xfer(PORT_DATA, make_cmd(1'b1, 32'hBFD0_03F0, $random(seed), 4'hF), d_rsp);
        join
        check_val("fetch_rsp_o.fault", f_rsp.fault, 1);
        check_val("fetch_rsp_o.rdata", f_rsp.rdata, 0);
        check_val("data_rsp_o.fault", d_rsp.fault, 1);
        check_val("data_rsp_o.rdata", d_rsp.rdata, 0);
        report_test("unmapped address");
    endtask

    initial begin
        rst_i       = 1'b1;
        fetch_req_i = 1'b0;
        fetch_cmd_i = '0;
        data_req_i  = 1'b0;
        data_cmd_i  = '0;
        rx_valid_i  = 1'b0;
        rx_data_i   = 8'h00;
        fail_tests  = 0;
        total_errs  = 0;
        repeat (10) @(negedge clk_25M);
        rst_i = 1'b0;

        test_base_masks();
        test_ext_fetch();
        test_same_bank();
        test_split_banks();
        test_serial();
        test_unmapped();

        $display("6 tests, %0d failed, %0d failed checks", fail_tests, total_errs);
        if (fail_tests == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: mem_bus_top.sv
module mem_bus_top #(
    parameter int BANK_WORDS = 256  // words per bank
) (
    input  logic                  clk_25M,
    input  logic                  rst_i,
    input  logic                  fetch_req_i,
    input  mem_bus_pkg::bus_req_t fetch_cmd_i,
    output logic                  fetch_ack_o,
    output mem_bus_pkg::bus_rsp_t fetch_rsp_o,
    input  logic                  data_req_i,
    input  mem_bus_pkg::bus_req_t data_cmd_i,
    output logic                  data_ack_o,
    output mem_bus_pkg::bus_rsp_t data_rsp_o,
    output logic                  tx_valid_o,
    output logic [7:0]            tx_data_o,
    input  logic                  tx_ack_i,
    input  logic                  rx_valid_i,
    input  logic [7:0]            rx_data_i,
    output logic                  rx_ack_o
);

    logic                           fetch_pend, data_pend;
    mem_bus_pkg::bus_req_t          fetch_cmd, data_cmd;
    mem_bus_pkg::region_e           fetch_region, data_region;
    logic                           fetch_done, data_done;
    mem_bus_pkg::bus_rsp_t          fetch_rsp, data_rsp;
    logic                           base_en, ext_en;
    mem_bus_pkg::bank_req_t         base_req, ext_req;
    logic [mem_bus_pkg::DATA_W-1:0] base_rdata, ext_rdata;
    logic                           uart_rd, uart_wr, uart_busy;
    logic [7:0]                     uart_wdata;
    logic [mem_bus_pkg::DATA_W-1:0] uart_rdata, uart_status;

    bus_port u_fetch_port (
        .clk_25M, .rst_i, .req_i(fetch_req_i), .cmd_i(fetch_cmd_i),
        .ack_o(fetch_ack_o), .rsp_o(fetch_rsp_o), .pend_o(fetch_pend),
        .cmd_o(fetch_cmd), .region_o(fetch_region), .done_i(fetch_done), .rsp_i(fetch_rsp)
    );

    bus_port u_data_port (
        .clk_25M, .rst_i, .req_i(data_req_i), .cmd_i(data_cmd_i),
        .ack_o(data_ack_o), .rsp_o(data_rsp_o), .pend_o(data_pend),
        .cmd_o(data_cmd), .region_o(data_region), .done_i(data_done), .rsp_i(data_rsp)
    );

    bus_arbiter #(.BANK_WORDS(BANK_WORDS)) u_arbiter (
        .clk_25M, .rst_i,
        .fetch_pend_i(fetch_pend), .fetch_cmd_i(fetch_cmd), .fetch_region_i(fetch_region),
        .fetch_done_o(fetch_done), .fetch_rsp_o(fetch_rsp),
        .data_pend_i(data_pend), .data_cmd_i(data_cmd), .data_region_i(data_region),
        .data_done_o(data_done), .data_rsp_o(data_rsp),
        .base_en_o(base_en), .base_req_o(base_req), .base_rdata_i(base_rdata),
        .ext_en_o(ext_en), .ext_req_o(ext_req), .ext_rdata_i(ext_rdata),
        .uart_rd_o(uart_rd), .uart_wr_o(uart_wr), .uart_wdata_o(uart_wdata),
        .uart_busy_i(uart_busy), .uart_rdata_i(uart_rdata), .uart_status_i(uart_status)
    );

    sram_bank #(.BANK_WORDS(BANK_WORDS)) u_base_bank (
        .clk_25M, .en_i(base_en), .req_i(base_req), .rdata_o(base_rdata)
    );

    sram_bank #(.BANK_WORDS(BANK_WORDS)) u_ext_bank (
        .clk_25M, .en_i(ext_en), .req_i(ext_req), .rdata_o(ext_rdata)
    );

    uart_regs u_uart_regs (
        .clk_25M, .rst_i, .rd_i(uart_rd), .wr_i(uart_wr), .wdata_i(uart_wdata),
        .busy_o(uart_busy), .rdata_o(uart_rdata), .status_o(uart_status),
        .tx_valid_o, .tx_data_o, .tx_ack_i, .rx_valid_i, .rx_data_i, .rx_ack_o
    );

endmodule

// File: uart_regs.sv
module uart_regs (
    input  logic                           clk_25M,
    input  logic                           rst_i,
    input  logic                           rd_i,
    input  logic                           wr_i,
    input  logic [7:0]                     wdata_i,
    output logic                           busy_o,
    output logic [mem_bus_pkg::DATA_W-1:0] rdata_o,
    output logic [mem_bus_pkg::DATA_W-1:0] status_o,
    output logic                           tx_valid_o,
    output logic [7:0]                     tx_data_o,
    input  logic                           tx_ack_i,
    input  logic                           rx_valid_i,
    input  logic [7:0]                     rx_data_i,
    output logic                           rx_ack_o
);

    logic       tx_full_q;
    logic       rx_full_q;
    logic [7:0] rx_byte_q;

    always_ff @(posedge clk_25M) begin
        if (rst_i) begin
            tx_full_q  <= 1'b0;
            tx_valid_o <= 1'b0;
            rx_full_q  <= 1'b0;
            rx_ack_o   <= 1'b0;
        end else begin
            // transmit side
            if (wr_i) begin
                tx_full_q <= 1'b1;
            end else if (tx_valid_o && tx_ack_i) begin
                tx_full_q <= 1'b0;  // handshake done, holding reg free
            end
            if (tx_valid_o && tx_ack_i) begin
                tx_valid_o <= 1'b0;
            end else if (tx_full_q && !tx_valid_o && !tx_ack_i) begin
                tx_valid_o <= 1'b1;  // previous ack must be gone first
            end

            // receive side, no ack while a byte is still unread
            if (rd_i) rx_full_q <= 1'b0;
            if (rx_valid_i && !rx_ack_o && !rx_full_q) begin
                rx_full_q <= 1'b1;
                rx_ack_o  <= 1'b1;
            end else if (rx_ack_o && !rx_valid_i) begin
                rx_ack_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_25M) begin
        if (wr_i) tx_data_o <= wdata_i;
        if (rx_valid_i && !rx_ack_o && !rx_full_q) rx_byte_q <= rx_data_i;
        if (rd_i) begin
            rdata_o <= rx_full_q ? {{(mem_bus_pkg::DATA_W-8){1'b0}}, rx_byte_q} : '0;
        end
    end

    assign busy_o   = tx_full_q;
    assign status_o = {{(mem_bus_pkg::DATA_W-2){1'b0}}, rx_full_q, !tx_full_q};

endmodule

// File: sram_bank.sv
module sram_bank #(
    parameter int BANK_WORDS = 256
) (
    input  logic                           clk_25M,
    input  logic                           en_i,
    input  mem_bus_pkg::bank_req_t         req_i,
    output logic [mem_bus_pkg::DATA_W-1:0] rdata_o
);

    localparam int BANK_AW = $clog2(BANK_WORDS);

    logic [mem_bus_pkg::DATA_W-1:0] mem [BANK_WORDS];
    logic [BANK_AW-1:0]             idx;

    assign idx = req_i.index[BANK_AW-1:0];

    always_ff @(posedge clk_25M) begin
        if (en_i) begin
            if (req_i.write) begin
                for (int b = 0; b < mem_bus_pkg::MASK_W; b++) begin
                    if (req_i.mask[b]) begin
                        mem[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                    end
                end
            end
            rdata_o <= mem[idx];  // old word on a write
        end
    end

endmodule

// File: bus_arbiter.sv
module bus_arbiter #(
    parameter int BANK_WORDS = 256
) (
    input  logic                                clk_25M,
    input  logic                                rst_i,
    input  logic                                fetch_pend_i,
    input  mem_bus_pkg::bus_req_t               fetch_cmd_i,
    input  mem_bus_pkg::region_e                fetch_region_i,
    output logic                                fetch_done_o,
    output mem_bus_pkg::bus_rsp_t               fetch_rsp_o,
    input  logic                                data_pend_i,
    input  mem_bus_pkg::bus_req_t               data_cmd_i,
    input  mem_bus_pkg::region_e                data_region_i,
    output logic                                data_done_o,
    output mem_bus_pkg::bus_rsp_t               data_rsp_o,
    output logic                                base_en_o,
    output mem_bus_pkg::bank_req_t              base_req_o,
    input  logic [mem_bus_pkg::DATA_W-1:0]      base_rdata_i,
    output logic                                ext_en_o,
    output mem_bus_pkg::bank_req_t              ext_req_o,
    input  logic [mem_bus_pkg::DATA_W-1:0]      ext_rdata_i,
    output logic                                uart_rd_o,
    output logic                                uart_wr_o,
    output logic [7:0]                          uart_wdata_o,
    input  logic                                uart_busy_i,
    input  logic [mem_bus_pkg::DATA_W-1:0]      uart_rdata_i,
    input  logic [mem_bus_pkg::DATA_W-1:0]      uart_status_i
);

    localparam int   BANK_AW   = $clog2(BANK_WORDS);
    localparam logic OWN_FETCH = 1'b0;
    localparam logic OWN_DATA  = 1'b1;

    logic f_served_q, d_served_q;  // issued, waiting for pend to drop
    logic f_want, f_base, f_ext, f_uart, f_none;
    logic d_want, d_base, d_ext, d_uart, d_none;
    logic d_uart_wr;
    logic d_go;
    logic uart_act_q;              // serial slot in use this cycle
    logic base_own_q, ext_own_q, uart_own_q;

    function automatic mem_bus_pkg::bank_req_t to_bank(mem_bus_pkg::bus_req_t cmd,
                                                       logic allow_wr);
        mem_bus_pkg::bank_req_t r;
        r.write = cmd.write & allow_wr;
        r.index = '0;
        r.index[BANK_AW-1:0] = cmd.addr[BANK_AW+1:2];  // aliases inside the window
        r.wdata = cmd.wdata;
        r.mask  = cmd.mask;
        return r;
    endfunction

    function automatic mem_bus_pkg::bus_rsp_t form_rsp(mem_bus_pkg::region_e region);
        mem_bus_pkg::bus_rsp_t r;
        r.fault = 1'b0;
        case (region)
            mem_bus_pkg::REGION_BASE:      r.rdata = base_rdata_i;
            mem_bus_pkg::REGION_EXT:       r.rdata = ext_rdata_i;
            mem_bus_pkg::REGION_UART_DATA: r.rdata = uart_rdata_i;
            mem_bus_pkg::REGION_UART_STAT: r.rdata = uart_status_i;
            default: begin
                r.rdata = '0;
                r.fault = 1'b1;
            end
        endcase
        return r;
    endfunction

    always_comb begin
        f_want = fetch_pend_i && !f_served_q;
        f_base = f_want && fetch_region_i == mem_bus_pkg::REGION_BASE;
        f_ext  = f_want && fetch_region_i == mem_bus_pkg::REGION_EXT;
        f_uart = f_want && (fetch_region_i == mem_bus_pkg::REGION_UART_DATA ||
                            fetch_region_i == mem_bus_pkg::REGION_UART_STAT);
        f_none = f_want && fetch_region_i == mem_bus_pkg::REGION_NONE;

        d_want = data_pend_i && !d_served_q;
        d_base = d_want && data_region_i == mem_bus_pkg::REGION_BASE;
        d_ext  = d_want && data_region_i == mem_bus_pkg::REGION_EXT;
        d_uart = d_want && (data_region_i == mem_bus_pkg::REGION_UART_DATA ||
                            data_region_i == mem_bus_pkg::REGION_UART_STAT);
        d_none = d_want && data_region_i == mem_bus_pkg::REGION_NONE;
        d_uart_wr = data_cmd_i.write && data_region_i == mem_bus_pkg::REGION_UART_DATA;

        // fetch has priority, data waits a slot on a clash or a full tx register
        d_go = d_want && !(d_base && f_base) && !(d_ext && f_ext) && !(d_uart && f_uart)
               && !(d_uart_wr && uart_busy_i);

        fetch_rsp_o = form_rsp(fetch_region_i);
        data_rsp_o  = form_rsp(data_region_i);
    end

    always_ff @(posedge clk_25M) begin
        if (rst_i) begin
            f_served_q   <= 1'b0;
            d_served_q   <= 1'b0;
            base_en_o    <= 1'b0;
            ext_en_o     <= 1'b0;
            uart_act_q   <= 1'b0;
            uart_rd_o    <= 1'b0;
            uart_wr_o    <= 1'b0;
            fetch_done_o <= 1'b0;
            data_done_o  <= 1'b0;
        end else begin
            if (f_want) f_served_q <= 1'b1;
            else if (!fetch_pend_i) f_served_q <= 1'b0;
            if (d_go) d_served_q <= 1'b1;
            else if (!data_pend_i) d_served_q <= 1'b0;

            base_en_o  <= f_base || (d_go && d_base);
            ext_en_o   <= f_ext || (d_go && d_ext);
            uart_act_q <= f_uart || (d_go && d_uart);
            // fetch writes become reads
            uart_rd_o  <= (f_uart && fetch_region_i == mem_bus_pkg::REGION_UART_DATA) ||
                          (d_go && data_region_i == mem_bus_pkg::REGION_UART_DATA &&
                           !data_cmd_i.write);
            uart_wr_o  <= d_go && d_uart_wr;

            // results land one cycle after issue, faults one cycle after seen
            fetch_done_o <= (base_en_o && base_own_q == OWN_FETCH) ||
                            (ext_en_o && ext_own_q == OWN_FETCH) ||
                            (uart_act_q && uart_own_q == OWN_FETCH) || f_none;
            data_done_o  <= (base_en_o && base_own_q == OWN_DATA) ||
                            (ext_en_o && ext_own_q == OWN_DATA) ||
                            (uart_act_q && uart_own_q == OWN_DATA) || (d_go && d_none);
        end
    end

    always_ff @(posedge clk_25M) begin
        base_req_o   <= f_base ? to_bank(fetch_cmd_i, 1'b0) : to_bank(data_cmd_i, 1'b1);
        ext_req_o    <= f_ext ? to_bank(fetch_cmd_i, 1'b0) : to_bank(data_cmd_i, 1'b1);
        base_own_q   <= f_base ? OWN_FETCH : OWN_DATA;
        ext_own_q    <= f_ext ? OWN_FETCH : OWN_DATA;
        uart_own_q   <= f_uart ? OWN_FETCH : OWN_DATA;
        uart_wdata_o <= data_cmd_i.wdata[7:0];
    end

endmodule

// File: bus_port.sv
module bus_port (
    input  logic                  clk_25M,
    input  logic                  rst_i,
    input  logic                  req_i,
    input  mem_bus_pkg::bus_req_t cmd_i,
    output logic                  ack_o,
    output mem_bus_pkg::bus_rsp_t rsp_o,
    output logic                  pend_o,
    output mem_bus_pkg::bus_req_t cmd_o,
    output mem_bus_pkg::region_e  region_o,
    input  logic                  done_i,
    input  mem_bus_pkg::bus_rsp_t rsp_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PEND,  // captured, waiting on the arbiter
        ST_ACK    // response held, waiting for req to drop
    } state_e;

    state_e               state_q;
    mem_bus_pkg::region_e region_d;

    // address decode, used only at capture
    always_comb begin
        region_d = mem_bus_pkg::REGION_NONE;
        if (cmd_i.addr >= mem_bus_pkg::BASE_START && cmd_i.addr <= mem_bus_pkg::BASE_END) begin
            region_d = mem_bus_pkg::REGION_BASE;
        end else if (cmd_i.addr >= mem_bus_pkg::EXT_START &&
                     cmd_i.addr <= mem_bus_pkg::EXT_END) begin
            region_d = mem_bus_pkg::REGION_EXT;
        end else if (cmd_i.addr == mem_bus_pkg::UART_DATA_ADDR) begin
            region_d = mem_bus_pkg::REGION_UART_DATA;
        end else if (cmd_i.addr == mem_bus_pkg::UART_STAT_ADDR) begin
            region_d = mem_bus_pkg::REGION_UART_STAT;
        end
    end

    always_ff @(posedge clk_25M) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: if (req_i) state_q <= ST_PEND;
                ST_PEND: if (done_i) state_q <= ST_ACK;
                ST_ACK:  if (!req_i) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_25M) begin
        if (state_q == ST_IDLE && req_i) begin
            cmd_o    <= cmd_i;
            region_o <= region_d;
        end
        if (state_q == ST_PEND && done_i) begin
            rsp_o <= rsp_i;
        end
    end

    assign pend_o = (state_q == ST_PEND);
    assign ack_o  = (state_q == ST_ACK);

endmodule

// File: mem_bus_pkg.sv
package mem_bus_pkg;

    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;
    parameter int MASK_W = 4;

    // widest word index inside one 4 MB window
    parameter int BANK_IDX_W = 20;

    // address map
    parameter logic [ADDR_W-1:0] BASE_START     = 32'h8000_0000;
    parameter logic [ADDR_W-1:0] BASE_END       = 32'h803F_FFFF;
    parameter logic [ADDR_W-1:0] EXT_START      = 32'h8040_0000;
    parameter logic [ADDR_W-1:0] EXT_END        = 32'h807F_FFFF;
    parameter logic [ADDR_W-1:0] UART_DATA_ADDR = 32'hBFD0_03F8;
    parameter logic [ADDR_W-1:0] UART_STAT_ADDR = 32'hBFD0_03FC;

    typedef enum logic [2:0] {
        REGION_BASE,
        REGION_EXT,
        REGION_UART_DATA,
        REGION_UART_STAT,
        REGION_NONE
    } region_e;

    // cpu side command, 69 bits
    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [MASK_W-1:0] mask;
    } bus_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              fault;  // unmapped address
    } bus_rsp_t;

    // bank side command, only the low BANK_AW index bits are used by a bank
    typedef struct packed {
        logic                  write;
        logic [BANK_IDX_W-1:0] index;
        logic [DATA_W-1:0]     wdata;
        logic [MASK_W-1:0]     mask;
    } bank_req_t;

endpackage
